// File: design/hello_pkg.sv
// Register map and bus types shared by the hello-world register block
// Address decode is exact on all 32 bits and there is no address aliasing
package hello_pkg;

  // ------------------------------------------------
  // Widths that carry a meaning
  // ------------------------------------------------
  // Byte address on the control bus
  typedef logic [31:0] addr_t;
  // One bus data word
  typedef logic [31:0] data_t;
  // Byte lane strobes that the registers ignore
  typedef logic [3:0]  strb_t;
  // AXI response code
  typedef logic [1:0]  resp_t;
  // One bit per virtual LED or DIP switch
  typedef logic [15:0] led_t;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  localparam addr_t VLED_ADDR        = 32'h0000_0504;

  // Read data for any address outside the map
  localparam data_t UNIMPL_VALUE = 32'hdead_dead;

  // Only response ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  // ------------------------------------------------
  // Bus bundles
  // ------------------------------------------------
  // Host to slave
  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } ocl_req_t;

  // Slave to host
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } ocl_rsp_t;

  // Single-cycle write strobe into the register file
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } reg_wr_t;

endpackage

// File: design/ocl_slave.sv
// Single-beat AXI-Lite slave and one outstanding access per channel
// Write strobes are ignored and every response is OKAY
`timescale 1ns/100ps

module ocl_slave import hello_pkg::*; (
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  input  ocl_req_t req,
  output ocl_rsp_t rsp,
  output reg_wr_t  reg_wr,
  output addr_t    rd_addr,
  input  data_t    rd_data
);

  // Write channel state
  logic  wr_active;
  addr_t wr_addr;
  logic  aw_fire;
  logic  wready;
  logic  bvalid;

  // Read channel state
  logic  rd_pending;
  addr_t rd_addr_q;
  logic  ar_fire;
  logic  arready;
  logic  rvalid;
  data_t rdata;

  // ------------------------------------------------
  // Write address
  // ------------------------------------------------
  // Address taken whenever no write is in flight
  assign aw_fire = req.awvalid && !wr_active;

  // Active from address accept until the B beat is taken
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && req.bready) begin
      wr_active <= 1'b0;
    end else if (aw_fire) begin
      wr_active <= 1'b1;
    end
  end

  // Target address for the data beat
  always_ff @(posedge clk_main_a0) begin
    if (aw_fire) begin
      wr_addr <= req.awaddr;
    end
  end

  // ------------------------------------------------
  // Write data and response
  // ------------------------------------------------
  // Data accepted combinationally once the address is held
  assign wready = wr_active && req.wvalid;

  // B beat raised the edge after the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && req.bready) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  // Register write lands on the data beat edge
  assign reg_wr.en   = wready;
  assign reg_wr.addr = wr_addr;
  assign reg_wr.data = req.wdata;

  // ------------------------------------------------
  // Read address
  // ------------------------------------------------
  // Blocked while a lookup or a response is outstanding
  assign arready = !rd_pending && !rvalid;
  assign ar_fire = req.arvalid && arready;

  // One-cycle lookup slot after accept
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= ar_fire;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_fire) begin
      rd_addr_q <= req.araddr;
    end
  end

  // Decode in the register file works from the latched address
  assign rd_addr = rd_addr_q;

  // ------------------------------------------------
  // Read response
  // ------------------------------------------------
  // Handshake clears the beat back to zero
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (rvalid && req.rready) begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end else if (rd_pending) begin
      rvalid <= 1'b1;
      rdata  <= rd_data;
    end
  end

  // Host-facing bundle
  always_comb begin
    rsp.awready = !wr_active;
    rsp.wready  = wready;
    rsp.bvalid  = bvalid;
    rsp.bresp   = RESP_OKAY;
    rsp.arready = arready;
    rsp.rvalid  = rvalid;
    rsp.rdata   = rdata;
    rsp.rresp   = RESP_OKAY;
  end

  // ------------------------------------------------
  // Protocol checks
  // ------------------------------------------------
  // R beat frozen under back-pressure
  a_rdata_hold : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !req.rready |=> rvalid && $stable(rdata)
  ) else $error("read response changed while rready was low");

  // B beat only after a data beat and only inside the write it answers
  a_bvalid_cause : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid |-> wr_active && (!$rose(bvalid) || $past(wready))
  ) else $error("bvalid without an active write and a preceding wready");

endmodule

// File: design/hello_regs.sv
// Hello-world word and LED shadow with a combinational read decode
// Writes to unmapped or read-only addresses are dropped silently
`timescale 1ns/100ps

module hello_regs import hello_pkg::*; (
  input  logic    clk_main_a0,
  input  logic    rst_main_n_sync,
  input  reg_wr_t reg_wr,
  input  addr_t   rd_addr,
  output data_t   rd_data,
  output led_t    vled_shadow
);

  data_t hello_q;
  data_t hello_swapped;
  led_t  shadow_q;
  logic  hello_wr;

  // ------------------------------------------------
  // Hello-world register
  // ------------------------------------------------
  // Only an exact address match writes
  assign hello_wr = reg_wr.en && (reg_wr.addr == HELLO_WORLD_ADDR);

  // Full word replace on every write
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (hello_wr) begin
      hello_q <= reg_wr.data;
    end
  end

  // Reads return the bytes in reverse order
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ------------------------------------------------
  // LED shadow
  // ------------------------------------------------
  // Low half of the word one cycle behind
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= hello_q[15:0];
    end
  end

  assign vled_shadow = shadow_q;

  // ------------------------------------------------
  // Read decode
  // ------------------------------------------------
  // Upper half of the LED read is zero
  always_comb begin
    case (rd_addr)
      HELLO_WORLD_ADDR: rd_data = hello_swapped;
      VLED_ADDR:        rd_data = {16'h0000, shadow_q};
      default:          rd_data = UNIMPL_VALUE;
    endcase
  end

endmodule

// File: design/vled_out.sv
// Virtual LED driver masked by the DIP switches
// DIP inputs are treated as asynchronous and pass two flops before use
`timescale 1ns/100ps

module vled_out import hello_pkg::*; (
  input  logic clk_main_a0,
  input  logic rst_main_n_sync,
  input  led_t vled_shadow,
  input  led_t vdip,
  output led_t vled
);

  led_t vdip_q1;
  led_t vdip_q2;
  led_t vled_q;

  // ------------------------------------------------
  // DIP synchronizer
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  // ------------------------------------------------
  // Masked output flop
  // ------------------------------------------------
  // A switch that is off forces its LED dark
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= vled_shadow & vdip_q2;
    end
  end

  assign vled = vled_q;

  // First value computed out of reset is still dark
  a_vled_reset : assert property (
    @(posedge clk_main_a0)
    $rose(rst_main_n_sync) |=> (vled == '0)
  ) else $error("vled not cleared after reset");

endmodule

// File: design/hello_top.sv
// Hello-world register block behind one AXI-Lite control port
// Clock and reset are assumed to come in already synchronous to each other
`timescale 1ns/100ps

module hello_top import hello_pkg::*; (
  input  logic     clk_main_a0,
  input  logic     rst_main_n_sync,
  input  ocl_req_t ocl_req,
  output ocl_rsp_t ocl_rsp,
  input  led_t     vdip,
  output led_t     vled
);

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------
  // Slave to register file
  reg_wr_t reg_wr;
  addr_t   rd_addr;
  // Register file back to slave
  data_t   rd_data;
  // Register file to LED stage
  led_t    vled_shadow;

  // Bus slave
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req             (ocl_req),
    .rsp             (ocl_rsp),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Register file
  hello_regs u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vled_shadow     (vled_shadow)
  );

  // LED output stage
  vled_out u_vled_out (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vled_shadow     (vled_shadow),
    .vdip            (vdip),
    .vled            (vled)
  );

endmodule

// File: dv/tb_hello_tasks.svh
// Bus driver and compare tasks, included inside the testbench module
// Relies on the module's ocl_req, ocl_rsp, HS_LIMIT and error counters
`ifndef TB_HELLO_TASKS_SVH
`define TB_HELLO_TASKS_SVH

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_data(input data_t got, input data_t exp, input string what);
  if (got !== exp) begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_led(input led_t got, input led_t exp, input string what);
  if (got !== exp) begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_resp(input resp_t got, input resp_t exp, input string what);
  if (got !== exp) begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

// Handshake flags and stalls
task automatic protocol_error(input string what);
  protocol_count++;
  $display("ERROR at %0t: %s", $time, what);
endtask

// --------------------------------------------------
// Bus write with the B beat held off for hold cycles
// --------------------------------------------------
task automatic bus_write(input addr_t addr, input data_t data, input int hold,
                         output resp_t resp);
  int cycles;
  cycles = 0;
  resp = 'x;
  @(negedge clk_main_a0);
  ocl_req.awvalid = 1'b1;
  ocl_req.awaddr  = addr;
  ocl_req.wvalid  = 1'b1;
  ocl_req.wdata   = data;
  ocl_req.wstrb   = '1;
  ocl_req.bready  = 1'b0;
  // wready only shows once the address is held
  if (ocl_rsp.wready) protocol_error("wready high before the write address was accepted");
  while (!ocl_rsp.awready && cycles < HS_LIMIT) begin
    @(negedge clk_main_a0);
    cycles++;
  end
  if (!ocl_rsp.awready) begin
    protocol_error($sformatf("write to %h not accepted within %0d cycles", addr, HS_LIMIT));
  end else begin
    // Address taken on the edge in between
    @(negedge clk_main_a0);
    ocl_req.awvalid = 1'b0;
    cycles = 0;
    while (!ocl_rsp.wready && cycles < HS_LIMIT) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (!ocl_rsp.wready) begin
      protocol_error($sformatf("no wready for %h within %0d cycles", addr, HS_LIMIT));
    end else begin
      // Data beat lands on the coming edge
      cycles = 0;
      do begin
        @(negedge clk_main_a0);
        ocl_req.wvalid = 1'b0;
        cycles++;
      end while (!ocl_rsp.bvalid && cycles < HS_LIMIT);
      if (!ocl_rsp.bvalid) begin
        protocol_error($sformatf("no write response for %h within %0d cycles", addr, HS_LIMIT));
      end else begin
        resp = ocl_rsp.bresp;
        repeat (hold) begin
          @(negedge clk_main_a0);
          if (!ocl_rsp.bvalid) protocol_error("bvalid dropped while bready was low");
          if (ocl_rsp.awready) protocol_error("awready rose before the B beat was taken");
          check_resp(ocl_rsp.bresp, resp, "bresp under back-pressure");
        end
        ocl_req.bready = 1'b1;
        @(negedge clk_main_a0);
        ocl_req.bready = 1'b0;
        if (ocl_rsp.bvalid) protocol_error("bvalid still high after bready");
        if (!ocl_rsp.awready) protocol_error("awready low after the B beat was taken");
      end
    end
  end
  ocl_req.awvalid = 1'b0;
  ocl_req.wvalid  = 1'b0;
endtask

// --------------------------------------------------
// Bus read with the R beat held off for hold cycles
// --------------------------------------------------
task automatic bus_read(input addr_t addr, input int hold, output data_t data,
                        output resp_t resp);
  int cycles;
  cycles = 0;
  data = 'x;
  resp = 'x;
  @(negedge clk_main_a0);
  ocl_req.arvalid = 1'b1;
  ocl_req.araddr  = addr;
  ocl_req.rready  = 1'b0;
  while (!ocl_rsp.arready && cycles < HS_LIMIT) begin
    @(negedge clk_main_a0);
    cycles++;
  end
  if (!ocl_rsp.arready) begin
    protocol_error($sformatf("read of %h not accepted within %0d cycles", addr, HS_LIMIT));
  end else begin
    // Address taken on the edge in between
    @(negedge clk_main_a0);
    ocl_req.arvalid = 1'b0;
    cycles = 0;
    while (!ocl_rsp.rvalid && cycles < HS_LIMIT) begin
      @(negedge clk_main_a0);
      cycles++;
    end
    if (!ocl_rsp.rvalid) begin
      protocol_error($sformatf("no read data for %h within %0d cycles", addr, HS_LIMIT));
    end else begin
      data = ocl_rsp.rdata;
      resp = ocl_rsp.rresp;
      repeat (hold) begin
        @(negedge clk_main_a0);
        if (!ocl_rsp.rvalid) protocol_error("rvalid dropped while rready was low");
        if (ocl_rsp.arready) protocol_error("arready rose before the R beat was taken");
        check_data(ocl_rsp.rdata, data, "rdata under back-pressure");
        check_resp(ocl_rsp.rresp, resp, "rresp under back-pressure");
      end
      ocl_req.rready = 1'b1;
      @(negedge clk_main_a0);
      ocl_req.rready = 1'b0;
      if (ocl_rsp.rvalid) protocol_error("rvalid still high after rready");
      if (!ocl_rsp.arready) protocol_error("arready low after the R beat was taken");
    end
  end
  ocl_req.arvalid = 1'b0;
endtask

`endif

// File: dv/tb_hello_top.sv
// Directed testbench for the hello-world register block
// Random data comes from a fixed seed, so every run is repeatable
`timescale 1ns/100ps

module tb_hello_top import hello_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 6;
  // Longest wait for any one handshake step
  localparam int HS_LIMIT   = 20;

  logic     clk_main_a0;
  logic     rst_main_n_sync;
  ocl_req_t ocl_req;
  ocl_rsp_t ocl_rsp;
  led_t     vdip;
  led_t     vled;

  int mismatch_count;
  int protocol_count;
  int seed;

  hello_top dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  always #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;

  `include "tb_hello_tasks.svh"

  // --------------------------------------------------
  // Reference model and random helpers
  // --------------------------------------------------
  // Byte 0 of the write comes back as byte 3
  function automatic data_t byte_reverse(input data_t w);
    data_t r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return r;
  endfunction

  function automatic data_t rand_word();
    data_t w;
    w = $random(seed);
    return w;
  endfunction

  // Back-pressure length of 1 to 8 cycles
  function automatic int rand_hold();
    int r;
    r = $random(seed) & 7;
    return r + 1;
  endfunction

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    data_t got;
    resp_t resp;
    check_led(vled, '0, "vled after reset");
    bus_read(HELLO_WORLD_ADDR, 0, got, resp);
    check_data(got, '0, "hello-world after reset");
    check_resp(resp, RESP_OKAY, "read response after reset");
    bus_read(VLED_ADDR, 0, got, resp);
    check_data(got, '0, "LED shadow after reset");
    check_resp(resp, RESP_OKAY, "read response after reset");
  endtask

  task automatic test_byte_swap();
    data_t w;
    data_t got;
    resp_t resp;
    repeat (8) begin
      w = rand_word();
      bus_write(HELLO_WORLD_ADDR, w, 0, resp);
      check_resp(resp, RESP_OKAY, "hello-world write response");
      bus_read(HELLO_WORLD_ADDR, 0, got, resp);
      check_data(got, byte_reverse(w), "hello-world read");
      check_resp(resp, RESP_OKAY, "hello-world read response");
    end
  endtask

  task automatic test_led_shadow();
    data_t w;
    data_t got;
    resp_t resp;
    repeat (4) begin
      w = rand_word();
      bus_write(HELLO_WORLD_ADDR, w, 0, resp);
      bus_read(VLED_ADDR, 0, got, resp);
      check_data(got, {16'h0000, w[15:0]}, "LED shadow read");
      check_resp(resp, RESP_OKAY, "LED shadow read response");
    end
  endtask

  task automatic test_unmapped();
    addr_t probe [4];
    data_t w;
    data_t got;
    resp_t resp;
    probe[0] = 32'h0000_0000;
    probe[1] = 32'h0000_0508;
    probe[2] = 32'h0000_04fc;
    probe[3] = rand_word() ^ 32'h0001_0000;
    w = rand_word();
    bus_write(HELLO_WORLD_ADDR, w, 0, resp);
    for (int i = 0; i < 4; i++) begin
      bus_read(probe[i], 0, got, resp);
      check_data(got, UNIMPL_VALUE, "unmapped read");
      check_resp(resp, RESP_OKAY, "unmapped read response");
      // Stray write must not reach the hello-world word
      bus_write(probe[i], ~w, 0, resp);
      check_resp(resp, RESP_OKAY, "unmapped write response");
      bus_read(HELLO_WORLD_ADDR, 0, got, resp);
      check_data(got, byte_reverse(w), "hello-world after unmapped write");
    end
  endtask

  task automatic test_led_mask();
    data_t w;
    data_t sw;
    resp_t resp;
    repeat (3) begin
      w  = rand_word();
      sw = rand_word();
      @(negedge clk_main_a0);
      vdip = sw[15:0];
      bus_write(HELLO_WORLD_ADDR, w, 0, resp);
      repeat (5) @(negedge clk_main_a0);
      check_led(vled, w[15:0] & sw[15:0], "vled after write");
      // DIP change alone
      sw = rand_word();
      vdip = sw[15:0];
      repeat (5) @(negedge clk_main_a0);
      check_led(vled, w[15:0] & sw[15:0], "vled after DIP change");
    end
  endtask

  task automatic test_back_pressure();
    data_t w;
    data_t got;
    resp_t resp;
    repeat (6) begin
      w = rand_word();
      bus_write(HELLO_WORLD_ADDR, w, rand_hold(), resp);
      check_resp(resp, RESP_OKAY, "write response under back-pressure");
      bus_read(HELLO_WORLD_ADDR, rand_hold(), got, resp);
      check_data(got, byte_reverse(w), "hello-world read under back-pressure");
      check_resp(resp, RESP_OKAY, "read response under back-pressure");
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    seed            = 32'h1d01_1327;
    mismatch_count  = 0;
    protocol_count  = 0;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    ocl_req         = '0;
    vdip            = '0;
    repeat (2) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    test_reset_state();
    test_byte_swap();
    test_led_shadow();
    test_unmapped();
    test_led_mask();
    test_back_pressure();
    $display("Errors: %0d mismatches, %0d protocol failures", mismatch_count, protocol_count);
    if (mismatch_count == 0 && protocol_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Run length bound of 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("ERROR at %0t: watchdog expired before the tests finished", $time);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+dv
design/hello_pkg.sv
design/ocl_slave.sv
design/hello_regs.sv
design/vled_out.sv
design/hello_top.sv
dv/tb_hello_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the hello_top testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

ROOT="$(cd "$(dirname "$0")" && pwd)"
BUILD_DIR="obj_dir"
LOG="sim.log"
EXE="sim_hello"

cd "$ROOT"
if [ $? -ne 0 ]; then
  echo "cannot enter project root $ROOT"
  exit 1
fi

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_hello_top -f filelist.f -Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^Simulation PASSED$" "$LOG"
if [ $? -ne 0 ]; then
  echo "pass line not found in $LOG"
  exit 1
fi

exit 0
